//--- rtl/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Datapath and architectural state
`define XLEN 32
`define ARCH_REGS 32
`define PREG_COUNT 64

// Buffer depths, IQ_DEPTH is also the sender's starting credit
`define IQ_DEPTH 4
`define ROB_DEPTH 8
`define RS_SIZE 4

// One CDB entry per ALU
`define N_ALU 2

`endif

//--- rtl/ooo_pkg.sv
`include "ooo_defines.svh"

package ooo_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef logic [$clog2(`ARCH_REGS)-1:0] areg_t;
    typedef logic [$clog2(`PREG_COUNT)-1:0] preg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    // writes_rd is low for NOPs and for rd == x0
    typedef struct packed {
        alu_op_e op;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
        logic [`XLEN-1:0] imm;
        logic use_imm;
        logic writes_rd;
    } decoded_inst_t;

    typedef struct packed {
        logic valid;
        alu_op_e op;
        logic [`XLEN-1:0] imm;
        logic use_imm;
        rob_tag_t rob_tag;
        preg_t src1_preg;
        logic src1_ready;
        preg_t src2_preg;
        logic src2_ready;
        preg_t dst_preg;
        preg_t old_preg;
        areg_t rd;
        logic writes_rd;
    } dispatch_t;

    typedef struct packed {
        logic valid;
        alu_op_e op;
        logic [`XLEN-1:0] imm;
        logic use_imm;
        preg_t src1_preg;
        preg_t src2_preg;
        preg_t dst_preg;
        rob_tag_t rob_tag;
    } issue_t;

    typedef struct packed {
        logic [`XLEN-1:0] src1_value;
        logic [`XLEN-1:0] src2_value;
    } operands_t;

    typedef struct packed {
        logic valid;
        preg_t dst_preg;
        rob_tag_t rob_tag;
        logic [`XLEN-1:0] value;
    } cdb_entry_t;

    // free_valid and old_preg are consumed by rename only
    typedef struct packed {
        logic valid;
        areg_t rd;
        logic [`XLEN-1:0] value;
        logic free_valid;
        preg_t old_preg;
    } commit_t;

endpackage

//--- rtl/rv32_decoder.sv
`include "ooo_defines.svh"

module rv32_decoder (
    input  logic [`XLEN-1:0]       inst,
    output ooo_pkg::decoded_inst_t decoded
);
    import ooo_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic alt;
    logic is_alu;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    // funct7 bit 5 selects SUB and SRA
    assign alt = inst[30];
    assign is_alu = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);

    always_comb begin
        decoded = '0;
        decoded.op = ALU_ADD;
        // Anything else falls through as a NOP
        if (is_alu) begin
            decoded.rd = inst[11:7];
            decoded.rs1 = inst[19:15];
            decoded.writes_rd = inst[11:7] != 5'd0;
            decoded.use_imm = opcode == OPC_OP_IMM;
            if (opcode == OPC_OP) begin
                decoded.rs2 = inst[24:20];
            end else begin
                decoded.imm = {{20{inst[31]}}, inst[31:20]};
            end
            case (funct3)
                3'b000: decoded.op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
                3'b001: decoded.op = ALU_SLL;
                3'b010: decoded.op = ALU_SLT;
                3'b011: decoded.op = ALU_SLTU;
                3'b100: decoded.op = ALU_XOR;
                3'b101: decoded.op = alt ? ALU_SRA : ALU_SRL;
                3'b110: decoded.op = ALU_OR;
                3'b111: decoded.op = ALU_AND;
            endcase
            // Shift immediates carry only the shamt
            if (decoded.use_imm && funct3[1:0] == 2'b01) begin
                decoded.imm = {27'd0, inst[24:20]};
            end
        end
    end

endmodule

//--- rtl/inst_queue.sv
`include "ooo_defines.svh"

module inst_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  logic                   pop,
    input  ooo_pkg::decoded_inst_t din,
    output ooo_pkg::decoded_inst_t head,
    output logic                   empty,
    output logic                   inst_credit
);
    import ooo_pkg::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    decoded_inst_t slots [`IQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0] count;

    assign head = slots[rd_ptr];
    assign empty = count == '0;
    // Each entry leaving hands one credit back to the sender
    assign inst_credit = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

endmodule

//--- rtl/rename_unit.sv
`include "ooo_defines.svh"

module rename_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  ooo_pkg::decoded_inst_t head,
    input  logic                   empty,
    input  logic                   rob_full,
    input  ooo_pkg::rob_tag_t      rob_tag,
    input  logic                   rs_full,
    input  logic [1:0]             src_ready,
    output ooo_pkg::preg_t [1:0]   src_preg,
    input  ooo_pkg::commit_t       commit,
    output logic                   pop,
    output ooo_pkg::dispatch_t     dispatch
);
    import ooo_pkg::*;

    preg_t rat [`ARCH_REGS];
    logic [`PREG_COUNT-1:0] free_map;
    preg_t new_preg;
    logic have_free;
    logic alloc;

    // Lowest numbered free preg
    always_comb begin
        new_preg = '0;
        for (int i = `PREG_COUNT - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                new_preg = preg_t'(i);
            end
        end
    end

    assign have_free = |free_map;
    assign src_preg[0] = rat[head.rs1];
    assign src_preg[1] = rat[head.rs2];

    // Non-writing instructions skip the RS and need no preg
    assign pop = !empty && !rob_full && (!head.writes_rd || (!rs_full && have_free));
    assign alloc = pop && head.writes_rd;

    always_comb begin
        dispatch.valid = pop;
        dispatch.op = head.op;
        dispatch.imm = head.imm;
        dispatch.use_imm = head.use_imm;
        dispatch.rob_tag = rob_tag;
        dispatch.src1_preg = src_preg[0];
        dispatch.src1_ready = src_ready[0];
        dispatch.src2_preg = src_preg[1];
        dispatch.src2_ready = src_ready[1];
        dispatch.dst_preg = head.writes_rd ? new_preg : '0;
        dispatch.old_preg = rat[head.rd];
        dispatch.rd = head.rd;
        dispatch.writes_rd = head.writes_rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, upper half of the file free
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rat[i] <= preg_t'(i);
            end
            free_map <= {{(`PREG_COUNT - `ARCH_REGS){1'b1}}, {`ARCH_REGS{1'b0}}};
        end else begin
            if (commit.free_valid) begin
                free_map[commit.old_preg] <= 1'b1;
            end
            if (alloc) begin
                rat[head.rd] <= new_preg;
                free_map[new_preg] <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/phys_reg_file.sv
`include "ooo_defines.svh"

module phys_reg_file (
    input  logic                                clk,
    input  logic                                rst,
    input  ooo_pkg::dispatch_t                  dispatch,
    input  ooo_pkg::cdb_entry_t [`N_ALU-1:0]    cdb,
    input  ooo_pkg::preg_t [1:0]                src_preg,
    output logic [1:0]                          src_ready,
    input  ooo_pkg::issue_t [`N_ALU-1:0]        issue,
    output ooo_pkg::operands_t [`N_ALU-1:0]     operands
);
    logic [`XLEN-1:0] values [`PREG_COUNT];
    logic [`PREG_COUNT-1:0] ready;

    // A result on the CDB this cycle already counts as ready
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_ready[s] = ready[src_preg[s]];
            for (int c = 0; c < `N_ALU; c++) begin
                if (cdb[c].valid && cdb[c].dst_preg == src_preg[s]) begin
                    src_ready[s] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `N_ALU; i++) begin
            operands[i].src1_value = values[issue[i].src1_preg];
            operands[i].src2_value = values[issue[i].src2_preg];
        end
    end

    // p0 is never a destination, so it stays ready and zero
    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= '1;
            for (int i = 0; i < `PREG_COUNT; i++) begin
                values[i] <= '0;
            end
        end else begin
            for (int c = 0; c < `N_ALU; c++) begin
                if (cdb[c].valid) begin
                    values[cdb[c].dst_preg] <= cdb[c].value;
                    ready[cdb[c].dst_preg] <= 1'b1;
                end
            end
            if (dispatch.valid && dispatch.writes_rd) begin
                ready[dispatch.dst_preg] <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/reservation_station.sv
`include "ooo_defines.svh"

module reservation_station (
    input  logic                                clk,
    input  logic                                rst,
    input  ooo_pkg::dispatch_t                  dispatch,
    input  ooo_pkg::cdb_entry_t [`N_ALU-1:0]    cdb,
    output logic                                rs_full,
    output ooo_pkg::issue_t [`N_ALU-1:0]        issue
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(`RS_SIZE);

    issue_t slot [`RS_SIZE];
    logic [`RS_SIZE-1:0] rdy1;
    logic [`RS_SIZE-1:0] rdy2;
    logic [`RS_SIZE-1:0] occupied;
    logic [`RS_SIZE-1:0] grant;
    logic [IDX_W-1:0] free_idx;
    issue_t incoming;

    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            occupied[i] = slot[i].valid;
        end
    end

    assign rs_full = &occupied;

    always_comb begin
        free_idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        incoming.valid = 1'b1;
        incoming.op = dispatch.op;
        incoming.imm = dispatch.imm;
        incoming.use_imm = dispatch.use_imm;
        incoming.src1_preg = dispatch.src1_preg;
        incoming.src2_preg = dispatch.src2_preg;
        incoming.dst_preg = dispatch.dst_preg;
        incoming.rob_tag = dispatch.rob_tag;
    end

    // Up to one ready entry per ALU, lowest index first
    always_comb begin
        int n;
        n = 0;
        grant = '0;
        issue = '0;
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (slot[i].valid && rdy1[i] && rdy2[i] && n < `N_ALU) begin
                issue[n] = slot[i];
                grant[i] = 1'b1;
                n++;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                slot[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (grant[i]) begin
                    slot[i].valid <= 1'b0;
                end
                // Wakeup from broadcast results
                for (int c = 0; c < `N_ALU; c++) begin
                    if (cdb[c].valid && cdb[c].dst_preg == slot[i].src1_preg) begin
                        rdy1[i] <= 1'b1;
                    end
                    if (cdb[c].valid && cdb[c].dst_preg == slot[i].src2_preg) begin
                        rdy2[i] <= 1'b1;
                    end
                end
            end
            // NOPs and rd == x0 never wait here
            if (dispatch.valid && dispatch.writes_rd) begin
                slot[free_idx] <= incoming;
                rdy1[free_idx] <= dispatch.src1_ready;
                rdy2[free_idx] <= dispatch.src2_ready;
            end
        end
    end

endmodule

//--- rtl/alu_unit.sv
`include "ooo_defines.svh"

module alu_unit (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::issue_t     issue,
    input  ooo_pkg::operands_t  operands,
    output ooo_pkg::cdb_entry_t result
);
    import ooo_pkg::*;

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] y;

    assign a = operands.src1_value;
    assign b = issue.use_imm ? issue.imm : operands.src2_value;

    always_comb begin
        case (issue.op)
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << b[4:0];
            ALU_SLT:  y = {{(`XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(`XLEN - 1){1'b0}}, a < b};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> b[4:0];
            ALU_SRA:  y = $unsigned($signed(a) >>> b[4:0]);
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = a + b;
        endcase
    end

    // Result reaches the CDB one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
        end
        result.dst_preg <= issue.dst_preg;
        result.rob_tag <= issue.rob_tag;
        result.value <= y;
    end

endmodule

//--- rtl/reorder_buffer.sv
`include "ooo_defines.svh"

module reorder_buffer (
    input  logic                                clk,
    input  logic                                rst,
    input  ooo_pkg::dispatch_t                  dispatch,
    input  ooo_pkg::cdb_entry_t [`N_ALU-1:0]    cdb,
    output logic                                rob_full,
    output ooo_pkg::rob_tag_t                   rob_tag,
    output ooo_pkg::commit_t                    commit
);
    import ooo_pkg::*;

    localparam int PTR_W = $clog2(`ROB_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = `ROB_DEPTH;

    areg_t rd [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] writes_rd;
    preg_t old_preg [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done;
    logic [`XLEN-1:0] value [`ROB_DEPTH];
    rob_tag_t head;
    rob_tag_t tail;
    logic [PTR_W:0] count;
    logic retire;
    logic retire_wr;

    assign rob_tag = tail;
    assign rob_full = count == FULL_COUNT;
    assign retire = (count != '0) && done[head];
    assign retire_wr = retire && writes_rd[head];

    // Non-writing retirements show rd 0 and value 0
    always_comb begin
        commit.valid = retire;
        commit.rd = retire_wr ? rd[head] : '0;
        commit.value = retire_wr ? value[head] : '0;
        commit.free_valid = retire_wr;
        commit.old_preg = old_preg[head];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (dispatch.valid) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, dispatch.valid} - {{PTR_W{1'b0}}, retire};
        end
        for (int c = 0; c < `N_ALU; c++) begin
            if (cdb[c].valid) begin
                done[cdb[c].rob_tag] <= 1'b1;
                value[cdb[c].rob_tag] <= cdb[c].value;
            end
        end
        if (dispatch.valid) begin
            rd[tail] <= dispatch.rd;
            writes_rd[tail] <= dispatch.writes_rd;
            old_preg[tail] <= dispatch.old_preg;
            done[tail] <= !dispatch.writes_rd;
        end
    end

endmodule

//--- rtl/ooo_core.sv
`include "ooo_defines.svh"

module ooo_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst,
    output logic             inst_credit,
    output ooo_pkg::commit_t commit
);
    import ooo_pkg::*;

    decoded_inst_t decoded;
    decoded_inst_t iq_head;
    logic iq_empty;
    logic iq_pop;
    dispatch_t dispatch;
    preg_t [1:0] src_preg;
    logic [1:0] src_ready;
    logic rob_full;
    logic rs_full;
    rob_tag_t rob_tag;
    issue_t [`N_ALU-1:0] issue;
    operands_t [`N_ALU-1:0] operands;
    cdb_entry_t [`N_ALU-1:0] cdb;

    rv32_decoder u_decoder (.inst(inst), .decoded(decoded));

    inst_queue u_iq (
        .clk(clk), .rst(rst), .push(inst_valid), .pop(iq_pop),
        .din(decoded), .head(iq_head), .empty(iq_empty), .inst_credit(inst_credit)
    );

    rename_unit u_rename (
        .clk(clk), .rst(rst), .head(iq_head), .empty(iq_empty),
        .rob_full(rob_full), .rob_tag(rob_tag), .rs_full(rs_full),
        .src_ready(src_ready), .src_preg(src_preg), .commit(commit),
        .pop(iq_pop), .dispatch(dispatch)
    );

    phys_reg_file u_prf (
        .clk(clk), .rst(rst), .dispatch(dispatch), .cdb(cdb),
        .src_preg(src_preg), .src_ready(src_ready),
        .issue(issue), .operands(operands)
    );

    reservation_station u_rs (
        .clk(clk), .rst(rst), .dispatch(dispatch), .cdb(cdb),
        .rs_full(rs_full), .issue(issue)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst), .dispatch(dispatch), .cdb(cdb),
        .rob_full(rob_full), .rob_tag(rob_tag), .commit(commit)
    );

    // ALU g owns CDB entry g
    for (genvar g = 0; g < `N_ALU; g++) begin : g_alu
        alu_unit u_alu (
            .clk(clk), .rst(rst), .issue(issue[g]),
            .operands(operands[g]), .result(cdb[g])
        );
    end

endmodule

//--- testbench/ooo_core_assert.sv
`include "ooo_defines.svh"

module ooo_core_assert (
    input logic                             clk,
    input logic                             rst,
    input logic                             inst_valid,
    input logic                             inst_credit,
    input ooo_pkg::commit_t                 commit,
    input ooo_pkg::cdb_entry_t [`N_ALU-1:0] cdb
);
    timeunit 1ns;
    timeprecision 1ps;

    // Queue occupancy seen from the core ports
    int occupancy;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(inst_valid) - int'(inst_credit);
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> occupancy < `IQ_DEPTH)
        else $error("instruction pushed into a full queue");

    a_quiet_after_reset: assert property (@(posedge clk)
        rst |=> !commit.valid && !inst_credit)
        else $error("commit or credit active right after reset");

    a_cdb_tags_unique: assert property (@(posedge clk) disable iff (rst)
        cdb[0].valid && cdb[1].valid |-> cdb[0].rob_tag != cdb[1].rob_tag)
        else $error("both CDB entries carry the same ROB tag");

    // p0 belongs to x0 and is never handed back to the free list
    a_commit_rd_valid: assert property (@(posedge clk) disable iff (rst)
        commit.rd != '0 |-> commit.valid && commit.old_preg != '0)
        else $error("commit with nonzero rd is not valid or frees p0");

endmodule

bind ooo_core ooo_core_assert u_core_assert (
    .clk(clk),
    .rst(rst),
    .inst_valid(inst_valid),
    .inst_credit(inst_credit),
    .commit(commit),
    .cdb(cdb)
);

//--- testbench/ooo_core_tb.sv
`include "ooo_defines.svh"

module ooo_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ooo_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED = 32'h7f689b06;

    logic clk;
    logic rst;
    logic inst_valid;
    logic [`XLEN-1:0] inst;
    logic inst_credit;
    commit_t commit;

    logic [31:0] rand_state;
    logic [`XLEN-1:0] arch [`ARCH_REGS];
    commit_t expected [$];
    int credits;
    int sent;
    int commits;
    int credit_pulses;
    int errors;
    bit timed_out;
    string cur_test;
    int test_errors;
    int test_sent;
    int test_commits;

    ooo_core uut (
        .clk(clk),
        .rst(rst),
        .inst_valid(inst_valid),
        .inst(inst),
        .inst_credit(inst_credit),
        .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Op numbering: 0..9 ADD SUB SLL SLT SLTU XOR SRL SRA OR AND,
    // 10..18 ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI
    function automatic logic [31:0] encode_alu(input int op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [11:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'h00;
        case (op)
            0, 10: f3 = 3'd0;
            1: begin
                f3 = 3'd0;
                f7 = 7'h20;
            end
            2, 16: f3 = 3'd1;
            3, 11: f3 = 3'd2;
            4, 12: f3 = 3'd3;
            5, 13: f3 = 3'd4;
            6, 17: f3 = 3'd5;
            7, 18: begin
                f3 = 3'd5;
                f7 = 7'h20;
            end
            8, 14: f3 = 3'd6;
            default: f3 = 3'd7;
        endcase
        if (op < 10) begin
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end
        if (op >= 16) begin
            return {f7, imm[4:0], rs1, f3, rd, 7'b0010011};
        end
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // RV32I result for one op
    function automatic logic [31:0] alu_result(input int op, input logic [31:0] a,
                                               input logic [31:0] b);
        case (op)
            0, 10: return a + b;
            1: return a - b;
            2, 16: return a << b[4:0];
            3, 11: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4, 12: return (a < b) ? 32'd1 : 32'd0;
            5, 13: return a ^ b;
            6, 17: return a >> b[4:0];
            7, 18: return $signed(a) >>> b[4:0];
            8, 14: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_commit(input string name, input commit_t exp, input commit_t got);
        if (got.valid !== exp.valid || got.rd !== exp.rd || got.value !== exp.value
                || got.free_valid !== exp.free_valid) begin
            errors++;
            $write("Error: %s commit %0d expected rd=x%0d value=%h free=%0b",
                   name, commits, exp.rd, exp.value, exp.free_valid);
            $display(", actual rd=x%0d value=%h free=%0b", got.rd, got.value, got.free_valid);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp) begin
            errors++;
            $display("Error: %s expected %0d, actual %0d", name, exp, got);
        end
    endtask

    task automatic take_commit(input commit_t got);
        commit_t exp;
        if (expected.size() == 0) begin
            errors++;
            $display("%s: a commit appeared with no instruction outstanding", cur_test);
        end else begin
            exp = expected.pop_front();
            check_commit(cur_test, exp, got);
        end
        commits++;
    endtask

    // One clock cycle of the sender, outputs sampled at the falling edge
    task automatic step(input logic valid, input logic [31:0] word);
        logic pulse;
        @(negedge clk);
        pulse = inst_credit;
        if (commit.valid) begin
            take_commit(commit);
        end
        inst_valid = valid;
        inst = word;
        if (valid) begin
            credits--;
            sent++;
        end
        // A returned credit is usable from the next cycle on
        if (pulse) begin
            credits++;
            credit_pulses++;
        end
    endtask

    task automatic wait_credit();
        int waited;
        waited = 0;
        while (credits == 0 && !timed_out) begin
            step(1'b0, '0);
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                $display("%s: no credit came back within %0d cycles", cur_test, waited);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected.size() != 0 && !timed_out) begin
            step(1'b0, '0);
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                $display("%s: %0d instructions still not committed after %0d cycles",
                         cur_test, expected.size(), waited);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic send_alu(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] b;
        logic [31:0] val;
        commit_t exp;
        wait_credit();
        if (timed_out) begin
            return;
        end
        if (op < 10) begin
            b = arch[rs2];
        end else if (op >= 16) begin
            b = {27'd0, imm[4:0]};
        end else begin
            b = {{20{imm[11]}}, imm};
        end
        val = alu_result(op, arch[rs1], b);
        exp = '0;
        exp.valid = 1'b1;
        if (rd != 5'd0) begin
            exp.rd = rd;
            exp.value = val;
            exp.free_valid = 1'b1;
            arch[rd] = val;
        end
        expected.push_back(exp);
        step(1'b1, encode_alu(op, rd, rs1, rs2, imm));
    endtask

    // LUI opcode, not an ALU op here
    task automatic send_nop();
        logic [31:0] r;
        commit_t exp;
        r = next_random();
        wait_credit();
        if (timed_out) begin
            return;
        end
        exp = '0;
        exp.valid = 1'b1;
        expected.push_back(exp);
        step(1'b1, {r[31:7], 7'b0110111});
    endtask

    // Registers from x0..x7 keep dependencies dense
    task automatic send_random(input logic to_x0);
        logic [31:0] r;
        logic [4:0] rd;
        int op;
        r = next_random();
        op = int'(next_random() >> 20) % 19;
        rd = to_x0 ? 5'd0 : {2'b00, r[27:25]};
        send_alu(op, rd, {2'b00, r[24:22]}, {2'b00, r[21:19]}, r[18:7]);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = errors;
        test_sent = sent;
        test_commits = commits;
    endtask

    task automatic end_test();
        wait_drain();
        check_count({cur_test, " commits"}, sent - test_sent, commits - test_commits);
        check_count({cur_test, " credits"}, `IQ_DEPTH, credits);
        if (timed_out) begin
            $display("%s: stopped by timeout", cur_test);
        end else if (errors == test_errors) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, errors - test_errors);
        end
    endtask

    initial begin
        logic [31:0] r;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        rand_state = SEED;
        credits = `IQ_DEPTH;
        sent = 0;
        commits = 0;
        credit_pulses = 0;
        errors = 0;
        timed_out = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            arch[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("after_reset");
        repeat (10) step(1'b0, '0);
        check_count("after_reset credit pulses", 0, credit_pulses);
        end_test();

        // Known sources in x1 and x2, each op then runs alone
        begin_test("single_ops");
        send_alu(10, 5'd1, 5'd0, 5'd0, 12'h9a5);
        send_alu(10, 5'd2, 5'd0, 5'd0, 12'h017);
        wait_drain();
        for (int op = 0; op < 19; op++) begin
            send_alu(op, 5'(3 + op % 5), 5'd1, 5'd2, 12'(next_random() >> 20));
            wait_drain();
        end
        end_test();

        begin_test("random_stream");
        repeat (300) send_random(1'b0);
        end_test();

        begin_test("sender_pauses");
        repeat (120) begin
            r = next_random();
            if (r[31:30] == 2'b00) begin
                repeat (int'(r[29:28]) + 1) step(1'b0, '0);
            end
            send_random(1'b0);
        end
        end_test();

        // Mix of x0 targets, NOPs and readers of the live registers
        begin_test("no_write");
        repeat (80) begin
            r = next_random();
            case (r[31:30])
                2'b00: send_random(1'b1);
                2'b01: send_nop();
                default: send_random(1'b0);
            endcase
        end
        end_test();

        $display("Totals: %0d sent, %0d committed, %0d errors", sent, commits, errors);
        if (timed_out || errors != 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/rv32_decoder.sv
rtl/inst_queue.sv
rtl/rename_unit.sv
rtl/phys_reg_file.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
testbench/ooo_core_assert.sv
testbench/ooo_core_tb.sv

//--- Makefile
TOP = ooo_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
